// File: dv/axi_mem_model.sv
//////////////////////////////////////////////////
// single-beat AXI-style memory slave of 16 KB
// byte address bits 13:2 pick the word
// random ready stalls and read latency from seed 79
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module axi_mem_model import mm_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // read channels
    input  addr_t araddr_i,
    input  logic  arvalid_i,
    output logic  arready_o,
    output row_t  rdata_o,
    output logic  rvalid_o,
    input  logic  rready_i,
    // write channels
    input  addr_t awaddr_i,
    input  logic  awvalid_i,
    output logic  awready_o,
    input  acc_t  wdata_i,
    input  logic  wvalid_i,
    output logic  wready_o,
    output logic  bvalid_o,
    input  logic  bready_i,
    // accepted requests for the testbench
    output logic  ar_take_o,
    output logic  aw_take_o
);

    localparam int MEM_WORDS = 4096;

    logic [31:0] mem [MEM_WORDS];

    // queued read data and write halves waiting for their partner
    logic [31:0] rd_q [$];
    addr_t       aw_q [$];
    acc_t        w_q  [$];

    integer      seed;
    logic [31:0] rnd;
    addr_t       waddr;
    int          lat_cnt;
    int          b_pend;
    // beats taken at posedge and acknowledged at negedge
    int          r_done_cnt;
    int          r_ack_cnt;
    int          b_done_cnt;
    int          b_ack_cnt;

    assign ar_take_o = arvalid_i && arready_o;
    assign aw_take_o = awvalid_i && awready_o;

    // handshakes and storage on the rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_q.delete();
            aw_q.delete();
            w_q.delete();
            b_pend     = 0;
            r_done_cnt = 0;
            b_done_cnt = 0;
            // fill from the byte address
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] = ~(w * 4);
            end
        end else begin
            if (arvalid_i && arready_o) begin
                rd_q.push_back(mem[araddr_i[13:2]]);
            end
            if (rvalid_o && rready_i) begin
                rd_q.delete(0);
                r_done_cnt++;
            end
            if (awvalid_i && awready_o) begin
                aw_q.push_back(awaddr_i);
            end
            if (wvalid_i && wready_o) begin
                w_q.push_back(wdata_i);
            end
            if (bvalid_o && bready_i) begin
                b_pend--;
                b_done_cnt++;
            end
            // commit once address and data are both in, then owe a response
            if (aw_q.size() > 0 && w_q.size() > 0) begin
                waddr = aw_q.pop_front();
                mem[waddr[13:2]] = w_q.pop_front();
                b_pend++;
            end
        end
    end

    // outputs change on the falling edge only
    initial begin
        seed      = 79;
        arready_o = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        bvalid_o  = 1'b0;
        lat_cnt   = 0;
        r_ack_cnt = 0;
        b_ack_cnt = 0;
        forever begin
            @(negedge clk);
            rnd = $random(seed);
            if (!rst_n) begin
                arready_o = 1'b0;
                awready_o = 1'b0;
                wready_o  = 1'b0;
                rvalid_o  = 1'b0;
                bvalid_o  = 1'b0;
                lat_cnt   = 0;
                r_ack_cnt = 0;
                b_ack_cnt = 0;
            end else begin
                // ready about three cycles in four
                arready_o = (rnd[1:0] != 2'b00);
                awready_o = (rnd[3:2] != 2'b00);
                wready_o  = (rnd[5:4] != 2'b00);
                if (r_ack_cnt != r_done_cnt) begin
                    r_ack_cnt = r_done_cnt;
                    rvalid_o  = 1'b0;
                end
                // next beat after 0 to 3 idle cycles
                if (!rvalid_o && rd_q.size() > 0) begin
                    if (lat_cnt == 0) begin
                        rvalid_o = 1'b1;
                        rdata_o  = rd_q[0];
                        lat_cnt  = int'(rnd[9:8]);
                    end else begin
                        lat_cnt--;
                    end
                end
                if (b_ack_cnt != b_done_cnt) begin
                    b_ack_cnt = b_done_cnt;
                    bvalid_o  = 1'b0;
                end
                if (!bvalid_o && b_pend > 0 && rnd[6]) begin
                    bvalid_o = 1'b1;
                end
            end
        end
    end

endmodule

// File: dv/tb_matmul_top.sv
//////////////////////////////////////////////////
// 20 random jobs against a testbench model of C
// A, B, C kept in disjoint memory regions
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module tb_matmul_top import mm_pkg::*; ();

    localparam int SA             = `MM_SA_WIDTH;
    localparam int NUM_READS      = 2 * SA;
    localparam int NUM_ELEMS      = SA * SA;
    localparam int NUM_JOBS       = 20;
    localparam int CYCLES_PER_JOB = 2000;

    logic  clk;
    logic  rst_n;
    logic  start_i;
    addr_t mat_a_addr;
    addr_t mat_b_addr;
    addr_t mat_c_addr;
    logic  done_o;
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    row_t  rdata;
    logic  rvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    acc_t  wdata;
    logic  wvalid;
    logic  wready;
    logic  bvalid;
    logic  bready;
    logic  ar_take;
    logic  aw_take;

    integer      seed;
    logic [31:0] rnd;

    // model operands and product
    elem_t a_m [SA][SA];
    elem_t b_m [SA][SA];
    acc_t  c_m [SA][SA];

    // expected addresses of the current job
    addr_t exp_ar [NUM_READS];
    addr_t exp_aw [NUM_ELEMS];

    // running totals kept by the monitor
    int ar_total;
    int r_total;
    int aw_total;
    int b_total;
    int done_cnt;
    int r_base;

    // pending requests from the previous edge
    logic  ar_hold;
    logic  aw_hold;
    logic  w_hold;
    addr_t ar_hold_addr;
    addr_t aw_hold_addr;
    acc_t  w_hold_data;

    matmul_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .done_o       (done_o),
        .araddr_o     (araddr),
        .arvalid_o    (arvalid),
        .arready_i    (arready),
        .rdata_i      (rdata),
        .rvalid_i     (rvalid),
        .rready_o     (rready),
        .awaddr_o     (awaddr),
        .awvalid_o    (awvalid),
        .awready_i    (awready),
        .wdata_o      (wdata),
        .wvalid_o     (wvalid),
        .wready_i     (wready),
        .bvalid_i     (bvalid),
        .bready_o     (bready)
    );

    axi_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .ar_take_o (ar_take),
        .aw_take_o (aw_take)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // protocol and ordering checks on every rising edge
    always @(posedge clk) begin
        if (!rst_n) begin
            ar_total = 0;
            r_total  = 0;
            aw_total = 0;
            b_total  = 0;
            done_cnt = 0;
            ar_hold  = 1'b0;
            aw_hold  = 1'b0;
            w_hold   = 1'b0;
        end else begin
            assert (!ar_hold || (arvalid && araddr == ar_hold_addr))
            else stop_run($sformatf("read request dropped or changed before arready at %0t ns",
                                    $time));
            assert (!aw_hold || (awvalid && awaddr == aw_hold_addr))
            else stop_run($sformatf("write address dropped or changed before awready at %0t ns",
                                    $time));
            assert (!w_hold || (wvalid && wdata == w_hold_data))
            else stop_run($sformatf("write data dropped or changed before wready at %0t ns",
                                    $time));
            if (ar_take) begin
                assert (araddr == exp_ar[ar_total % NUM_READS])
                else stop_run($sformatf("Mismatch at %0t ns: read address %h, expected %h",
                                        $time, araddr, exp_ar[ar_total % NUM_READS]));
                ar_total++;
            end
            if (rvalid && rready) begin
                r_total++;
            end
            if (aw_take) begin
                assert (r_total - r_base == NUM_READS)
                else stop_run($sformatf("write accepted before all reads returned at %0t ns",
                                        $time));
                assert (aw_total == b_total)
                else stop_run($sformatf("second write while a response was due at %0t ns",
                                        $time));
                assert (awaddr == exp_aw[aw_total % NUM_ELEMS])
                else stop_run($sformatf("Mismatch at %0t ns: write address %h, expected %h",
                                        $time, awaddr, exp_aw[aw_total % NUM_ELEMS]));
                aw_total++;
            end
            if (bvalid && bready) begin
                b_total++;
            end
            if (done_o) begin
                done_cnt++;
            end
            ar_hold      = arvalid && !arready;
            ar_hold_addr = araddr;
            aw_hold      = awvalid && !awready;
            aw_hold_addr = awaddr;
            w_hold       = wvalid && !wready;
            w_hold_data  = wdata;
        end
    end

    // one job from memory setup to result compare
    task automatic run_job(input int job);
        int   a_word;
        int   b_word;
        int   c_word;
        row_t row;
        rnd    = $random(seed);
        a_word = int'(rnd[7:0]) * 4;
        b_word = 1024 + int'(rnd[15:8]) * 4;
        c_word = 2048 + int'(rnd[22:16]) * 16;
        // operand rows into memory with element j in byte j
        for (int r = 0; r < SA; r++) begin
            for (int j = 0; j < SA; j++) begin
                rnd     = $random(seed);
                a_m[r][j] = rnd[7:0];
                b_m[r][j] = rnd[15:8];
            end
            for (int j = 0; j < SA; j++) begin
                row[j*`MM_ELEM_W +: `MM_ELEM_W] = a_m[r][j];
            end
            u_mem.mem[a_word + r] = row;
            for (int j = 0; j < SA; j++) begin
                row[j*`MM_ELEM_W +: `MM_ELEM_W] = b_m[r][j];
            end
            u_mem.mem[b_word + r] = row;
            exp_ar[r]      = addr_t'((a_word + r) * 4);
            exp_ar[SA + r] = addr_t'((b_word + r) * 4);
        end
        // reference product and stale fill of C
        for (int i = 0; i < SA; i++) begin
            for (int j = 0; j < SA; j++) begin
                c_m[i][j] = '0;
                for (int k = 0; k < SA; k++) begin
                    c_m[i][j] += acc_t'(a_m[i][k]) * acc_t'(b_m[k][j]);
                end
                u_mem.mem[c_word + i*SA + j] = ~((c_word + i*SA + j) * 4);
                exp_aw[i*SA + j] = addr_t'((c_word + i*SA + j) * 4);
            end
        end
        r_base = r_total;
        @(negedge clk);
        start_i    = 1'b1;
        mat_a_addr = addr_t'(a_word * 4);
        mat_b_addr = addr_t'(b_word * 4);
        mat_c_addr = addr_t'(c_word * 4);
        @(negedge clk);
        start_i = 1'b0;
        // stray starts with bogus bases while the job runs
        for (int p = 0; p < 2; p++) begin
            repeat (p == 0 ? 3 : 22) @(negedge clk);
            rnd        = $random(seed);
            start_i    = 1'b1;
            mat_a_addr = rnd;
            mat_b_addr = ~rnd;
            mat_c_addr = {rnd[15:0], rnd[31:16]};
            @(negedge clk);
            start_i = 1'b0;
        end
        while (done_cnt == job) begin
            @(negedge clk);
        end
        assert (done_cnt == job + 1 && ar_total == NUM_READS * (job + 1)
                && aw_total == NUM_ELEMS * (job + 1))
        else stop_run($sformatf("job %0d ended with wrong done, read or write count", job));
        for (int i = 0; i < SA; i++) begin
            for (int j = 0; j < SA; j++) begin
                assert (u_mem.mem[c_word + i*SA + j] == c_m[i][j])
                else stop_run($sformatf("Mismatch at %0t ns: job %0d C[%0d][%0d] = %0d, exp %0d",
                                        $time, job, i, j, u_mem.mem[c_word + i*SA + j],
                                        c_m[i][j]));
            end
        end
    endtask

    initial begin
        seed       = 79;
        rst_n      = 1'b0;
        start_i    = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        r_base     = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        // idle outputs before the first job
        assert (!done_o && !arvalid && !rready && !awvalid && !wvalid && !bready)
        else stop_run($sformatf("Mismatch at %0t ns: DUT outputs active with no job", $time));
        for (int job = 0; job < NUM_JOBS; job++) begin
            run_job(job);
        end
        repeat (5) @(negedge clk);
        assert (done_cnt == NUM_JOBS) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_run("extra done pulse after the last job");
        end
    end

    // watchdog over all jobs
    initial begin
        repeat (NUM_JOBS * CYCLES_PER_JOB) @(posedge clk);
        $display("timeout, jobs did not finish within %0d cycles", NUM_JOBS * CYCLES_PER_JOB);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// File: matmul_top.f
+incdir+verilog
verilog/mm_pkg.sv
verilog/row_buffer.sv
verilog/mm_engine.sv
verilog/dma_engine.sv
verilog/matmul_top.sv
dv/axi_mem_model.sv
dv/tb_matmul_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the matmul testbench with verilator
# the log decides pass or fail
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_matmul_top \
    -f matmul_top.f \
    -o sim_matmul

# simulator status is masked by tee, the log check below decides
./obj_dir/sim_matmul 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "run ok"
    exit 0
else
    echo "run failed, see sim.log"
    exit 1
fi

// File: verilog/dma_engine.sv
//////////////////////////////////////////////////
// single-beat AXI-style reads and writes only
// low two address bits are dropped, bresp ignored
// up to 2*SA_WIDTH reads in flight, one write
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module dma_engine import mm_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // job configuration
    input  logic                                          start_i,
    input  addr_t                                         mat_a_addr_i,
    input  addr_t                                         mat_b_addr_i,
    input  addr_t                                         mat_c_addr_i,
    output logic                                          done_o,
    // read address and data
    output addr_t                                         araddr_o,
    output logic                                          arvalid_o,
    input  logic                                          arready_i,
    input  row_t                                          rdata_i,
    input  logic                                          rvalid_i,
    output logic                                          rready_o,
    // write address, data, response
    output addr_t                                         awaddr_o,
    output logic                                          awvalid_o,
    input  logic                                          awready_i,
    output acc_t                                          wdata_o,
    output logic                                          wvalid_o,
    input  logic                                          wready_i,
    input  logic                                          bvalid_i,
    output logic                                          bready_o,
    // operand buffers
    output logic                                          buf_a_wren_o,
    output logic                                          buf_b_wren_o,
    output buf_idx_t                                      buf_widx_o,
    output row_t                                          buf_wdata_o,
    // multiply engine
    output logic                                          mm_start_o,
    input  logic                                          mm_done_i,
    input  logic [`MM_SA_WIDTH*`MM_SA_WIDTH*`MM_ACC_W-1:0] acc_i
);

    localparam int NUM_READS = 2 * `MM_SA_WIDTH;
    localparam int NUM_ELEMS = `MM_SA_WIDTH * `MM_SA_WIDTH;
    localparam int RD_CNT_W  = $clog2(NUM_READS + 1);
    localparam int EL_CNT_W  = $clog2(NUM_ELEMS);
    localparam int ROW_BYTES = `MM_BUS_W / 8;
    localparam int EL_BYTES  = `MM_ACC_W / 8;

    dma_state_t state_q;

    // issued read requests and returned beats
    logic [RD_CNT_W-1:0] req_cnt_q;
    logic [RD_CNT_W-1:0] ret_cnt_q;

    // current element of C, row-major
    logic [EL_CNT_W-1:0] elem_cnt_q;

    // address and data of this write accepted
    logic aw_done_q;
    logic w_done_q;

    logic mm_start_q;

    addr_t a_base_q;
    addr_t b_base_q;
    addr_t c_base_q;

    logic     ar_hs;
    logic     r_hs;
    logic     aw_hs;
    logic     w_hs;
    logic     b_hs;
    buf_idx_t req_row;

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    // sequencer and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            req_cnt_q  <= '0;
            ret_cnt_q  <= '0;
            elem_cnt_q <= '0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
            mm_start_q <= 1'b0;
        end else begin
            mm_start_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q   <= LOAD;
                        req_cnt_q <= '0;
                        ret_cnt_q <= '0;
                    end
                end
                LOAD: begin
                    if (ar_hs) begin
                        req_cnt_q <= req_cnt_q + 1'b1;
                    end
                    if (r_hs) begin
                        ret_cnt_q <= ret_cnt_q + 1'b1;
                        // eighth beat lands in buffer B this edge
                        if (ret_cnt_q == RD_CNT_W'(NUM_READS - 1)) begin
                            state_q    <= COMPUTE;
                            mm_start_q <= 1'b1;
                        end
                    end
                end
                COMPUTE: begin
                    if (mm_done_i) begin
                        state_q    <= STORE;
                        elem_cnt_q <= '0;
                        aw_done_q  <= 1'b0;
                        w_done_q   <= 1'b0;
                    end
                end
                STORE: begin
                    if (aw_hs) begin
                        aw_done_q <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done_q <= 1'b1;
                    end
                    // response closes the element, next pair may go out
                    if (b_hs) begin
                        aw_done_q  <= 1'b0;
                        w_done_q   <= 1'b0;
                        elem_cnt_q <= elem_cnt_q + 1'b1;
                        if (elem_cnt_q == EL_CNT_W'(NUM_ELEMS - 1)) begin
                            state_q <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // job base addresses, word aligned
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            a_base_q <= {mat_a_addr_i[`MM_BUS_W-1:2], 2'b00};
            b_base_q <= {mat_b_addr_i[`MM_BUS_W-1:2], 2'b00};
            c_base_q <= {mat_c_addr_i[`MM_BUS_W-1:2], 2'b00};
        end
    end

    // read requests, A rows first then B rows
    assign req_row   = buf_idx_t'(req_cnt_q);
    assign arvalid_o = (state_q == LOAD) && (req_cnt_q < RD_CNT_W'(NUM_READS));
    assign araddr_o  = ((req_cnt_q < RD_CNT_W'(`MM_SA_WIDTH)) ? a_base_q : b_base_q)
                       + addr_t'(req_row) * ROW_BYTES;

    // read data in request order
    assign rready_o = (state_q == LOAD);

    // beat goes straight into its buffer
    assign buf_a_wren_o = r_hs && (ret_cnt_q < RD_CNT_W'(`MM_SA_WIDTH));
    assign buf_b_wren_o = r_hs && (ret_cnt_q >= RD_CNT_W'(`MM_SA_WIDTH));
    assign buf_widx_o   = buf_idx_t'(ret_cnt_q);
    assign buf_wdata_o  = rdata_i;

    assign mm_start_o = mm_start_q;

    // write channels, address and data raised together
    assign awvalid_o = (state_q == STORE) && !aw_done_q;
    assign wvalid_o  = (state_q == STORE) && !w_done_q;
    assign awaddr_o  = c_base_q + addr_t'(elem_cnt_q) * EL_BYTES;
    assign wdata_o   = acc_i[elem_cnt_q*`MM_ACC_W +: `MM_ACC_W];

    // waiting on the response for the current element
    assign bready_o = (state_q == STORE);

    // cycle after the last response
    assign done_o = (state_q == FINISH);

endmodule

// File: verilog/matmul_top.sv
//////////////////////////////////////////////////
// 4x4 unsigned 8-bit matrix multiply, C = A * B
// start_i is ignored while a job is running
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module matmul_top import mm_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // job configuration
    input  logic  start_i,
    input  addr_t mat_a_addr_i,
    input  addr_t mat_b_addr_i,
    input  addr_t mat_c_addr_i,
    output logic  done_o,
    // read channels
    output addr_t araddr_o,
    output logic  arvalid_o,
    input  logic  arready_i,
    input  row_t  rdata_i,
    input  logic  rvalid_i,
    output logic  rready_o,
    // write channels
    output addr_t awaddr_o,
    output logic  awvalid_o,
    input  logic  awready_i,
    output acc_t  wdata_o,
    output logic  wvalid_o,
    input  logic  wready_i,
    input  logic  bvalid_i,
    output logic  bready_o
);

    logic     buf_a_wren;
    logic     buf_b_wren;
    buf_idx_t buf_widx;
    row_t     buf_wdata;
    logic     mm_start;
    logic     mm_done;

    // operand rows and results, flat
    logic [`MM_SA_WIDTH*`MM_BUS_W-1:0]              a_rows;
    logic [`MM_SA_WIDTH*`MM_BUS_W-1:0]              b_rows;
    logic [`MM_SA_WIDTH*`MM_SA_WIDTH*`MM_ACC_W-1:0] acc;

    dma_engine u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .done_o       (done_o),
        .araddr_o     (araddr_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .rdata_i      (rdata_i),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .awaddr_o     (awaddr_o),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .wdata_o      (wdata_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .buf_a_wren_o (buf_a_wren),
        .buf_b_wren_o (buf_b_wren),
        .buf_widx_o   (buf_widx),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .acc_i        (acc)
    );

    // matrix A rows
    row_buffer u_buf_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (buf_a_wren),
        .wr_idx_i  (buf_widx),
        .wr_data_i (buf_wdata),
        .rows_o    (a_rows)
    );

    // matrix B rows
    row_buffer u_buf_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (buf_b_wren),
        .wr_idx_i  (buf_widx),
        .wr_data_i (buf_wdata),
        .rows_o    (b_rows)
    );

    mm_engine u_mm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (mm_start),
        .a_rows_i (a_rows),
        .b_rows_i (b_rows),
        .done_o   (mm_done),
        .acc_o    (acc)
    );

endmodule

// File: verilog/mm_defines.svh
//////////////////////////////////////////////////
// sizes for the 4x4 matrix-multiply accelerator
// one bus beat carries one full matrix row
// accumulator must hold SA_WIDTH * 255 * 255
//////////////////////////////////////////////////

`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// matrix dimension, buffer depth, engine run length
`define MM_SA_WIDTH 4

// one unsigned element
`define MM_ELEM_W 8

// axi data and address width
`define MM_BUS_W 32

// accumulator and result width of C
`define MM_ACC_W 32

`endif

// File: verilog/mm_engine.sv
//////////////////////////////////////////////////
// sequential stand-in for a systolic mesh
// one k step per cycle, all 16 MACs in parallel
// done_o pulses SA_WIDTH+1 cycles after start_i
// results held until the next start_i
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module mm_engine import mm_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          start_i,
    input  logic [`MM_SA_WIDTH*`MM_BUS_W-1:0]             a_rows_i,
    input  logic [`MM_SA_WIDTH*`MM_BUS_W-1:0]             b_rows_i,
    output logic                                          done_o,
    output logic [`MM_SA_WIDTH*`MM_SA_WIDTH*`MM_ACC_W-1:0] acc_o
);

    mm_state_t state_q;
    buf_idx_t  k_q;

    // unpacked views of the operands
    elem_t a_el [`MM_SA_WIDTH][`MM_SA_WIDTH];
    elem_t b_el [`MM_SA_WIDTH][`MM_SA_WIDTH];

    acc_t acc_q [`MM_SA_WIDTH][`MM_SA_WIDTH];

    // row r, byte c of each flat buffer
    for (genvar r = 0; r < `MM_SA_WIDTH; r++) begin : g_row
        for (genvar c = 0; c < `MM_SA_WIDTH; c++) begin : g_col
            assign a_el[r][c] = a_rows_i[r*`MM_BUS_W + c*`MM_ELEM_W +: `MM_ELEM_W];
            assign b_el[r][c] = b_rows_i[r*`MM_BUS_W + c*`MM_ELEM_W +: `MM_ELEM_W];
            // C(r,c) at flat slot r*SA+c, row-major
            assign acc_o[(r*`MM_SA_WIDTH + c)*`MM_ACC_W +: `MM_ACC_W] = acc_q[r][c];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            k_q     <= '0;
            for (int i = 0; i < `MM_SA_WIDTH; i++) begin
                for (int j = 0; j < `MM_SA_WIDTH; j++) begin
                    acc_q[i][j] <= '0;
                end
            end
        end else begin
            case (state_q)
                MM_IDLE: begin
                    if (start_i) begin
                        state_q <= MM_RUN;
                        k_q     <= '0;
                        // fresh job, drop old results
                        for (int i = 0; i < `MM_SA_WIDTH; i++) begin
                            for (int j = 0; j < `MM_SA_WIDTH; j++) begin
                                acc_q[i][j] <= '0;
                            end
                        end
                    end
                end
                MM_RUN: begin
                    // C(i,j) += A(i,k) * B(k,j), product widened to acc width
                    for (int i = 0; i < `MM_SA_WIDTH; i++) begin
                        for (int j = 0; j < `MM_SA_WIDTH; j++) begin
                            acc_q[i][j] <= acc_q[i][j] + a_el[i][k_q] * b_el[k_q][j];
                        end
                    end
                    k_q <= k_q + 1'b1;
                    // last k step
                    if (k_q == buf_idx_t'(`MM_SA_WIDTH - 1)) begin
                        state_q <= MM_DONE;
                    end
                end
                MM_DONE: begin
                    state_q <= MM_IDLE;
                end
                default: begin
                    state_q <= MM_IDLE;
                end
            endcase
        end
    end

    // single cycle in MM_DONE gives the pulse
    assign done_o = (state_q == MM_DONE);

endmodule

// File: verilog/mm_pkg.sv
//////////////////////////////////////////////////
// shared types for the matmul accelerator
// widths come from mm_defines.svh
//////////////////////////////////////////////////

`include "mm_defines.svh"

package mm_pkg;

    // single matrix element
    typedef logic [`MM_ELEM_W-1:0] elem_t;

    // packed row, element j sits in byte j
    typedef logic [`MM_BUS_W-1:0] row_t;

    // byte address on the bus
    typedef logic [`MM_BUS_W-1:0] addr_t;

    // one entry of C
    typedef logic [`MM_ACC_W-1:0] acc_t;

    // row index into a buffer
    typedef logic [$clog2(`MM_SA_WIDTH)-1:0] buf_idx_t;

    // job sequencer
    typedef enum logic [2:0] {IDLE, LOAD, COMPUTE, STORE, FINISH} dma_state_t;

    // multiply engine
    typedef enum logic [1:0] {MM_IDLE, MM_RUN, MM_DONE} mm_state_t;

endpackage

// File: verilog/row_buffer.sv
//////////////////////////////////////////////////
// register buffer for one operand matrix
// written one row per cycle, read all at once
// write shows up on rows_o one cycle later
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mm_defines.svh"

module row_buffer import mm_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wr_en_i,
    input  buf_idx_t                           wr_idx_i,
    input  row_t                               wr_data_i,
    output logic [`MM_SA_WIDTH*`MM_BUS_W-1:0]  rows_o
);

    row_t rows_q [`MM_SA_WIDTH];

    // row storage, cleared at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `MM_SA_WIDTH; r++) begin
                rows_q[r] <= '0;
            end
        end else if (wr_en_i) begin
            rows_q[wr_idx_i] <= wr_data_i;
        end
    end

    // flatten, row r at bits r*BUS_W
    for (genvar r = 0; r < `MM_SA_WIDTH; r++) begin : g_flat
        assign rows_o[r*`MM_BUS_W +: `MM_BUS_W] = rows_q[r];
    end

endmodule
